//--- hdl/eth_frame_filter.sv
// ############################
// Frame filter by destination MAC.
// Takes one header per frame, decides accept or drop from the
// configuration, then passes the payload through or drains it.
// Emits one accept or drop pulse per frame.
// ############################

`timescale 1ns/1ps
`default_nettype none

module eth_frame_filter (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_rx_pkg::filter_cfg_t cfg,
    input  logic                    hdr_valid,
    input  eth_rx_pkg::eth_hdr_t    hdr,
    output logic                    hdr_ready,
    input  logic                    pay_valid,
    input  eth_rx_pkg::axis_byte_t  pay,
    output logic                    pay_ready,
    output logic                    out_hdr_valid,
    output eth_rx_pkg::eth_hdr_t    out_hdr,
    input  logic                    out_hdr_ready,
    output logic                    out_valid,
    output eth_rx_pkg::axis_byte_t  out,
    input  logic                    out_ready,
    output eth_rx_pkg::rx_event_t   events
);

    eth_rx_pkg::filter_state_t state_reg;
    eth_rx_pkg::eth_hdr_t      out_hdr_reg;

    logic out_hdr_valid_reg;
    logic accept_reg;
    logic drop_reg;
    logic hdr_fire;
    logic pay_done;
    logic dest_local;
    logic dest_bcast;
    logic accept;

    // one header per frame, and only once the previous one is gone
    assign hdr_ready = (state_reg == eth_rx_pkg::FS_IDLE) && !out_hdr_valid_reg;
    assign hdr_fire  = hdr_valid && hdr_ready;

    assign dest_local = hdr.dest_mac == cfg.local_mac;
    assign dest_bcast = hdr.dest_mac == eth_rx_pkg::MAC_BROADCAST;
    assign accept     = cfg.rx_enable && (dest_local || dest_bcast || cfg.promisc);

    assign pay_done = pay_valid && pay_ready && pay.last;

    assign out_hdr_valid = out_hdr_valid_reg;
    assign out_hdr       = out_hdr_reg;
    assign out           = pay;

    // header errors are counted from the parser directly
    assign events.accept  = accept_reg;
    assign events.drop    = drop_reg;
    assign events.hdr_err = 1'b0;

    always_comb begin
        out_valid = 1'b0;
        pay_ready = 1'b0;
        case (state_reg)
            eth_rx_pkg::FS_PASS: begin
                out_valid = pay_valid;
                pay_ready = out_ready;
            end
            eth_rx_pkg::FS_DROP: begin
                // drain and discard
                pay_ready = 1'b1;
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg         <= eth_rx_pkg::FS_IDLE;
            out_hdr_valid_reg <= 1'b0;
            accept_reg        <= 1'b0;
            drop_reg          <= 1'b0;
        end else begin
            accept_reg <= 1'b0;
            drop_reg   <= 1'b0;
            if (out_hdr_valid_reg && out_hdr_ready) begin
                out_hdr_valid_reg <= 1'b0;
            end
            case (state_reg)
                eth_rx_pkg::FS_IDLE: begin
                    if (hdr_fire) begin
                        if (accept) begin
                            state_reg         <= eth_rx_pkg::FS_PASS;
                            out_hdr_valid_reg <= 1'b1;
                            accept_reg        <= 1'b1;
                        end else begin
                            state_reg <= eth_rx_pkg::FS_DROP;
                            drop_reg  <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (pay_done) begin
                        state_reg <= eth_rx_pkg::FS_IDLE;
                    end
                end
            endcase
        end

        if (hdr_fire) begin
            out_hdr_reg <= hdr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_hdr_parser.sv
// ############################
// Ethernet header parser.
// Strips the 14 header bytes off the incoming byte stream and
// presents them as one header word with its own handshake.
// Payload bytes leave through a registered two-entry skid buffer.
// Frames ending inside the header raise hdr_err.
// ############################

`timescale 1ns/1ps
`default_nettype none

module eth_hdr_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  eth_rx_pkg::axis_byte_t in,
    output logic                   in_ready,
    output logic                   hdr_valid,
    output eth_rx_pkg::eth_hdr_t   hdr,
    input  logic                   hdr_ready,
    output logic                   pay_valid,
    output eth_rx_pkg::axis_byte_t pay,
    input  logic                   pay_ready,
    output logic                   busy,
    output logic                   hdr_err
);

    localparam eth_rx_pkg::hdr_idx_t HDR_LAST =
        eth_rx_pkg::hdr_idx_t'(eth_rx_pkg::ETH_HDR_LEN - 1);

    eth_rx_pkg::parser_state_t state_reg, state_next;
    eth_rx_pkg::hdr_idx_t      ptr_reg, ptr_next;
    eth_rx_pkg::eth_hdr_t      hdr_reg;

    logic in_ready_reg, in_ready_next;
    logic hdr_valid_reg, hdr_valid_next;
    logic hdr_err_reg, hdr_err_next;
    logic busy_reg;
    logic store_hdr;
    logic in_fire;

    // payload side of the FSM feeding the skid buffer
    eth_rx_pkg::axis_byte_t pay_int;
    logic                   pay_valid_int;
    logic                   pay_ready_int_reg;
    logic                   pay_ready_int_early;

    // output register and temp register
    eth_rx_pkg::axis_byte_t pay_reg, temp_reg;
    logic pay_valid_reg, pay_valid_next;
    logic temp_valid_reg, temp_valid_next;
    logic store_int_to_out;
    logic store_int_to_temp;
    logic store_temp_to_out;

    assign in_fire   = in_valid && in_ready_reg;
    assign in_ready  = in_ready_reg;
    assign hdr_valid = hdr_valid_reg;
    assign hdr       = hdr_reg;
    assign busy      = busy_reg;
    assign hdr_err   = hdr_err_reg;
    assign pay_valid = pay_valid_reg;
    assign pay       = pay_reg;

    always_comb begin
        state_next     = state_reg;
        ptr_next       = ptr_reg;
        in_ready_next  = 1'b0;
        hdr_valid_next = hdr_valid_reg && !hdr_ready;
        hdr_err_next   = 1'b0;
        store_hdr      = 1'b0;
        pay_int        = '0;
        pay_valid_int  = 1'b0;

        case (state_reg)
            eth_rx_pkg::PS_IDLE: begin
                // hold off a new frame until the last header is taken
                ptr_next      = '0;
                in_ready_next = !hdr_valid_reg;
                if (in_fire) begin
                    store_hdr = 1'b1;
                    if (in.last) begin
                        hdr_err_next = 1'b1;
                    end else begin
                        ptr_next      = 4'd1;
                        in_ready_next = 1'b1;
                        state_next    = eth_rx_pkg::PS_READ_HEADER;
                    end
                end
            end
            eth_rx_pkg::PS_READ_HEADER: begin
                in_ready_next = 1'b1;
                if (in_fire) begin
                    store_hdr = 1'b1;
                    ptr_next  = ptr_reg + 4'd1;
                    if (in.last) begin
                        // truncated frame so no header goes out
                        hdr_err_next  = 1'b1;
                        in_ready_next = !hdr_valid_reg;
                        state_next    = eth_rx_pkg::PS_IDLE;
                    end else if (ptr_reg == HDR_LAST) begin
                        hdr_valid_next = 1'b1;
                        in_ready_next  = pay_ready_int_early;
                        state_next     = eth_rx_pkg::PS_READ_PAYLOAD;
                    end
                end
            end
            eth_rx_pkg::PS_READ_PAYLOAD: begin
                in_ready_next = pay_ready_int_early;
                pay_int       = in;
                pay_valid_int = in_valid;
                if (in_fire && in.last) begin
                    in_ready_next = !hdr_valid_reg;
                    state_next    = eth_rx_pkg::PS_IDLE;
                end
            end
            default: begin
                state_next = eth_rx_pkg::PS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg     <= eth_rx_pkg::PS_IDLE;
            ptr_reg       <= '0;
            in_ready_reg  <= 1'b0;
            hdr_valid_reg <= 1'b0;
            hdr_err_reg   <= 1'b0;
            busy_reg      <= 1'b0;
        end else begin
            state_reg     <= state_next;
            ptr_reg       <= ptr_next;
            in_ready_reg  <= in_ready_next;
            hdr_valid_reg <= hdr_valid_next;
            hdr_err_reg   <= hdr_err_next;
            busy_reg      <= state_next != eth_rx_pkg::PS_IDLE;
        end

        // byte n of the header lands MSB first
        if (store_hdr) begin
            hdr_reg[(eth_rx_pkg::ETH_HDR_LEN - 1 - ptr_reg) * 8 +: 8] <= in.data;
        end
    end

    // input may be taken next cycle unless the temp slot would fill up
    assign pay_ready_int_early = pay_ready
                               || (!temp_valid_reg && (!pay_valid_reg || !pay_valid_int));

    always_comb begin
        pay_valid_next    = pay_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (pay_ready_int_reg) begin
            if (pay_ready || !pay_valid_reg) begin
                pay_valid_next   = pay_valid_int;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled so park the byte
                temp_valid_next   = pay_valid_int;
                store_int_to_temp = 1'b1;
            end
        end else if (pay_ready) begin
            pay_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pay_valid_reg     <= 1'b0;
            temp_valid_reg    <= 1'b0;
            pay_ready_int_reg <= 1'b0;
        end else begin
            pay_valid_reg     <= pay_valid_next;
            temp_valid_reg    <= temp_valid_next;
            pay_ready_int_reg <= pay_ready_int_early;
        end

        if (store_int_to_out) begin
            pay_reg <= pay_int;
        end else if (store_temp_to_out) begin
            pay_reg <= temp_reg;
        end

        if (store_int_to_temp) begin
            temp_reg <= pay_int;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_rx_pkg.sv
// ############################
// Shared types and constants for the Ethernet receive path.
// Parser, filter, register block and top level refer to these
// by scoped names.
// ############################

`default_nettype none

package eth_rx_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  hdr_idx_t;
    typedef logic [2:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // dest_mac sits in the top bits, so wire byte 0 is bits 111:104
    typedef struct packed {
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        eth_type_t eth_type;
    } eth_hdr_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_byte_t;

    typedef struct packed {
        mac_addr_t local_mac;
        logic      promisc;
        logic      rx_enable;
    } filter_cfg_t;

    // one-cycle pulses
    typedef struct packed {
        logic accept;
        logic drop;
        logic hdr_err;
    } rx_event_t;

    localparam int        ETH_HDR_LEN   = 14;
    localparam mac_addr_t MAC_BROADCAST = '1;

    localparam cfg_addr_t REG_MAC_LO      = 3'd0;
    localparam cfg_addr_t REG_MAC_HI      = 3'd1;
    localparam cfg_addr_t REG_CTRL        = 3'd2;
    localparam cfg_addr_t REG_CNT_ACCEPT  = 3'd3;
    localparam cfg_addr_t REG_CNT_DROP    = 3'd4;
    localparam cfg_addr_t REG_CNT_HDR_ERR = 3'd5;

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_READ_HEADER,
        PS_READ_PAYLOAD
    } parser_state_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_PASS,
        FS_DROP
    } filter_state_t;

endpackage

`default_nettype wire

//--- hdl/eth_rx_regs.sv
// ############################
// Configuration and statistics registers.
// Holds the local MAC and control bits for the filter and
// counts accepted, dropped and truncated frames.
// Reads return one cycle after cfg_rd.
// ############################

`timescale 1ns/1ps
`default_nettype none

module eth_rx_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_wr,
    input  logic                    cfg_rd,
    input  eth_rx_pkg::cfg_addr_t   cfg_addr,
    input  eth_rx_pkg::cfg_data_t   cfg_wdata,
    output eth_rx_pkg::cfg_data_t   cfg_rdata,
    output eth_rx_pkg::filter_cfg_t cfg,
    input  eth_rx_pkg::rx_event_t   events,
    input  logic                    hdr_err
);

    eth_rx_pkg::cfg_data_t mac_lo_reg;
    logic [15:0]           mac_hi_reg;
    logic                  rx_enable_reg;
    logic                  promisc_reg;
    eth_rx_pkg::cfg_data_t cnt_accept_reg;
    eth_rx_pkg::cfg_data_t cnt_drop_reg;
    eth_rx_pkg::cfg_data_t cnt_hdr_err_reg;

    assign cfg.local_mac = {mac_hi_reg, mac_lo_reg};
    assign cfg.promisc   = promisc_reg;
    assign cfg.rx_enable = rx_enable_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            mac_lo_reg      <= '0;
            mac_hi_reg      <= '0;
            rx_enable_reg   <= 1'b0;
            promisc_reg     <= 1'b0;
            cnt_accept_reg  <= '0;
            cnt_drop_reg    <= '0;
            cnt_hdr_err_reg <= '0;
            cfg_rdata       <= '0;
        end else begin
            if (cfg_wr) begin
                case (cfg_addr)
                    eth_rx_pkg::REG_MAC_LO: mac_lo_reg <= cfg_wdata;
                    eth_rx_pkg::REG_MAC_HI: mac_hi_reg <= cfg_wdata[15:0];
                    eth_rx_pkg::REG_CTRL: begin
                        rx_enable_reg <= cfg_wdata[0];
                        promisc_reg   <= cfg_wdata[1];
                    end
                    default: begin
                        // counters are read only
                    end
                endcase
            end

            // counters wrap
            cnt_accept_reg  <= cnt_accept_reg + 32'(events.accept);
            cnt_drop_reg    <= cnt_drop_reg + 32'(events.drop);
            cnt_hdr_err_reg <= cnt_hdr_err_reg + 32'(events.hdr_err || hdr_err);

            if (cfg_rd) begin
                case (cfg_addr)
                    eth_rx_pkg::REG_MAC_LO:      cfg_rdata <= mac_lo_reg;
                    eth_rx_pkg::REG_MAC_HI:      cfg_rdata <= {16'd0, mac_hi_reg};
                    eth_rx_pkg::REG_CTRL:        cfg_rdata <= {30'd0, promisc_reg, rx_enable_reg};
                    eth_rx_pkg::REG_CNT_ACCEPT:  cfg_rdata <= cnt_accept_reg;
                    eth_rx_pkg::REG_CNT_DROP:    cfg_rdata <= cnt_drop_reg;
                    eth_rx_pkg::REG_CNT_HDR_ERR: cfg_rdata <= cnt_hdr_err_reg;
                    default:                     cfg_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_rx_top.sv
// ############################
// Ethernet receive top level.
// Byte stream in, filtered header and payload out, with a small
// register port for configuration and statistics.
// ############################

`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  eth_rx_pkg::axis_byte_t in,
    output logic                   in_ready,
    output logic                   out_hdr_valid,
    output eth_rx_pkg::eth_hdr_t   out_hdr,
    input  logic                   out_hdr_ready,
    output logic                   out_valid,
    output eth_rx_pkg::axis_byte_t out,
    input  logic                   out_ready,
    input  logic                   cfg_wr,
    input  logic                   cfg_rd,
    input  eth_rx_pkg::cfg_addr_t  cfg_addr,
    input  eth_rx_pkg::cfg_data_t  cfg_wdata,
    output eth_rx_pkg::cfg_data_t  cfg_rdata,
    output logic                   busy
);

    // parser to filter
    logic                    hdr_valid;
    eth_rx_pkg::eth_hdr_t    hdr;
    logic                    hdr_ready;
    logic                    pay_valid;
    eth_rx_pkg::axis_byte_t  pay;
    logic                    pay_ready;

    // status and configuration
    logic                    hdr_err;
    eth_rx_pkg::filter_cfg_t cfg;
    eth_rx_pkg::rx_event_t   events;

    eth_hdr_parser i_parser (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in        (in),
        .in_ready  (in_ready),
        .hdr_valid (hdr_valid),
        .hdr       (hdr),
        .hdr_ready (hdr_ready),
        .pay_valid (pay_valid),
        .pay       (pay),
        .pay_ready (pay_ready),
        .busy      (busy),
        .hdr_err   (hdr_err)
    );

    eth_frame_filter i_filter (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .hdr_valid     (hdr_valid),
        .hdr           (hdr),
        .hdr_ready     (hdr_ready),
        .pay_valid     (pay_valid),
        .pay           (pay),
        .pay_ready     (pay_ready),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr       (out_hdr),
        .out_hdr_ready (out_hdr_ready),
        .out_valid     (out_valid),
        .out           (out),
        .out_ready     (out_ready),
        .events        (events)
    );

    eth_rx_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_rd    (cfg_rd),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg),
        .events    (events),
        .hdr_err   (hdr_err)
    );

endmodule

`default_nettype wire

//--- sources.f
hdl/eth_rx_pkg.sv
hdl/eth_hdr_parser.sv
hdl/eth_frame_filter.sv
hdl/eth_rx_regs.sv
hdl/eth_rx_top.sv
verif/tb_clk_gen.sv
verif/tb_eth_rx.sv

//--- verif/tb_clk_gen.sv
// ############################
// Testbench clock source.
// Free-running clock with a 4 ns period, starting low.
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verif/tb_eth_rx.sv
// ############################
// Testbench for the Ethernet receive path.
// Sends the frames of a table through eth_rx_top, checks the
// filtered header and payload against values built from the
// table, then reads back the statistics and MAC registers.
// out_ready is toggled at random for back-pressure.
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_eth_rx;

    localparam int NUM_FRAMES  = 12;
    localparam int WATCHDOG_NS = NUM_FRAMES * 80 * 8 * 4;
    localparam int IFG_CYCLES  = 2;

    localparam logic [1:0] DEST_LOCAL = 2'd0;
    localparam logic [1:0] DEST_BCAST = 2'd1;
    localparam logic [1:0] DEST_OTHER = 2'd2;

    localparam eth_rx_pkg::mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01;
    localparam eth_rx_pkg::mac_addr_t OTHER_MAC = 48'h02_00_00_00_00_77;

    // len counts payload bytes, or all wire bytes of a short frame
    typedef struct packed {
        logic [1:0]           dest_kind;
        logic [7:0]           len;
        eth_rx_pkg::byte_t    seed;
        eth_rx_pkg::eth_type_t eth_type;
        logic                 promisc;
        logic                 rx_enable;
        logic                 short_frame;
    } frame_entry_t;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    eth_rx_pkg::axis_byte_t  in_byte;
    logic                    in_ready;
    logic                    out_hdr_valid;
    eth_rx_pkg::eth_hdr_t    out_hdr;
    logic                    out_hdr_ready;
    logic                    out_valid;
    eth_rx_pkg::axis_byte_t  out_byte;
    logic                    out_ready;
    logic                    cfg_wr;
    logic                    cfg_rd;
    eth_rx_pkg::cfg_addr_t   cfg_addr;
    eth_rx_pkg::cfg_data_t   cfg_wdata;
    eth_rx_pkg::cfg_data_t   cfg_rdata;
    logic                    busy;

    frame_entry_t           frame_table [NUM_FRAMES];
    eth_rx_pkg::eth_hdr_t   exp_hdrs [$];
    eth_rx_pkg::axis_byte_t exp_bytes [$];

    integer seed        = 31;
    int     error_count = 0;
    int     check_count = 0;

    tb_clk_gen i_clk_gen (
        .clk (clk)
    );

    eth_rx_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in            (in_byte),
        .in_ready      (in_ready),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr       (out_hdr),
        .out_hdr_ready (out_hdr_ready),
        .out_valid     (out_valid),
        .out           (out_byte),
        .out_ready     (out_ready),
        .cfg_wr        (cfg_wr),
        .cfg_rd        (cfg_rd),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .busy          (busy)
    );

    task automatic fill_table();
        frame_table[0]  = '{DEST_LOCAL, 8'd20, 8'h10, 16'h0800, 1'b0, 1'b1, 1'b0};
        frame_table[1]  = '{DEST_BCAST, 8'd5,  8'hA0, 16'h0806, 1'b0, 1'b1, 1'b0};
        frame_table[2]  = '{DEST_OTHER, 8'd12, 8'h33, 16'h0800, 1'b0, 1'b1, 1'b0};
        frame_table[3]  = '{DEST_LOCAL, 8'd1,  8'hFF, 16'h86DD, 1'b0, 1'b1, 1'b0};
        // ends inside the header
        frame_table[4]  = '{DEST_LOCAL, 8'd9,  8'h00, 16'h0800, 1'b0, 1'b1, 1'b1};
        frame_table[5]  = '{DEST_LOCAL, 8'd30, 8'hF0, 16'h0800, 1'b0, 1'b1, 1'b0};
        frame_table[6]  = '{DEST_OTHER, 8'd16, 8'h01, 16'h88B5, 1'b1, 1'b1, 1'b0};
        frame_table[7]  = '{DEST_BCAST, 8'd3,  8'h5C, 16'h0806, 1'b1, 1'b1, 1'b0};
        // reception off
        frame_table[8]  = '{DEST_LOCAL, 8'd10, 8'h22, 16'h0800, 1'b0, 1'b0, 1'b0};
        frame_table[9]  = '{DEST_BCAST, 8'd7,  8'h44, 16'h0806, 1'b0, 1'b0, 1'b0};
        frame_table[10] = '{DEST_OTHER, 8'd1,  8'h00, 16'h0800, 1'b0, 1'b1, 1'b1};
        frame_table[11] = '{DEST_LOCAL, 8'd64, 8'h80, 16'h0800, 1'b0, 1'b1, 1'b0};
    endtask

    function automatic eth_rx_pkg::mac_addr_t dest_of(input logic [1:0] kind);
        case (kind)
            DEST_LOCAL: return LOCAL_MAC;
            DEST_BCAST: return eth_rx_pkg::MAC_BROADCAST;
            default:    return OTHER_MAC;
        endcase
    endfunction

    function automatic logic frame_accepted(input frame_entry_t e);
        return e.rx_enable
            && (e.dest_kind == DEST_LOCAL || e.dest_kind == DEST_BCAST || e.promisc);
    endfunction

    function automatic eth_rx_pkg::eth_hdr_t header_of(input int idx);
        eth_rx_pkg::eth_hdr_t h;
        h.dest_mac = dest_of(frame_table[idx].dest_kind);
        h.src_mac  = {40'h02_5A_00_00_00, 8'(idx)};
        h.eth_type = frame_table[idx].eth_type;
        return h;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    // a frame is in progress from its first byte until its last one is taken
    task automatic check_busy(input logic exp_val, input int idx, input int pos);
        check_count++;
        if (busy !== exp_val) begin
            report_error($sformatf("busy %0b after byte %0d of frame %0d, expected %0b",
                                   busy, pos, idx, exp_val));
        end
    endtask

    task automatic reg_write(input eth_rx_pkg::cfg_addr_t addr,
                             input eth_rx_pkg::cfg_data_t data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
    endtask

    // rdata is registered, so it is sampled one edge after the strobe
    task automatic reg_read(input eth_rx_pkg::cfg_addr_t addr,
                            output eth_rx_pkg::cfg_data_t data);
        cfg_rd   = 1'b1;
        cfg_addr = addr;
        @(posedge clk);
        #1;
        cfg_rd = 1'b0;
        data   = cfg_rdata;
    endtask

    task automatic check_reg(input eth_rx_pkg::cfg_addr_t addr,
                             input eth_rx_pkg::cfg_data_t exp_val, input string name);
        eth_rx_pkg::cfg_data_t got;
        reg_read(addr, got);
        check_count++;
        if (got !== exp_val) begin
            report_error($sformatf("%s read 0x%08h, expected 0x%08h", name, got, exp_val));
        end
    endtask

    // every frame ends as exactly one accept, drop or header error
    task automatic wait_decided(input int n);
        eth_rx_pkg::cfg_data_t acc;
        eth_rx_pkg::cfg_data_t drp;
        eth_rx_pkg::cfg_data_t err;
        int total;
        total = 0;
        while (total < n) begin
            reg_read(eth_rx_pkg::REG_CNT_ACCEPT, acc);
            reg_read(eth_rx_pkg::REG_CNT_DROP, drp);
            reg_read(eth_rx_pkg::REG_CNT_HDR_ERR, err);
            total = int'(acc + drp + err);
        end
    endtask

    task automatic send_byte(input eth_rx_pkg::byte_t data, input logic last);
        in_valid = 1'b1;
        in_byte  = '{data: data, last: last, user: 1'b0};
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input int idx);
        frame_entry_t      e;
        logic [111:0]      hdr_bits;
        eth_rx_pkg::byte_t data;
        int                n_bytes;
        e        = frame_table[idx];
        hdr_bits = header_of(idx);
        n_bytes  = e.short_frame ? int'(e.len) : eth_rx_pkg::ETH_HDR_LEN + int'(e.len);
        data     = e.seed;
        for (int j = 0; j < n_bytes; j++) begin
            if (j < eth_rx_pkg::ETH_HDR_LEN) begin
                send_byte(hdr_bits[111 - 8 * j -: 8], j == n_bytes - 1);
            end else begin
                send_byte(data, j == n_bytes - 1);
                data = data + 8'd1;
            end
            check_busy(j != n_bytes - 1, idx, j);
        end
        in_valid = 1'b0;
        in_byte  = '0;
    endtask

    // payload byte k is seed + k, wrapping at 256
    task automatic queue_expected(input int idx);
        eth_rx_pkg::byte_t      data;
        eth_rx_pkg::axis_byte_t b;
        int                     len;
        data = frame_table[idx].seed;
        len  = int'(frame_table[idx].len);
        exp_hdrs.push_back(header_of(idx));
        for (int k = 0; k < len; k++) begin
            b.data = data;
            b.last = (k == len - 1);
            b.user = 1'b0;
            exp_bytes.push_back(b);
            data = data + 8'd1;
        end
    endtask

    initial begin : stimulus
        frame_entry_t e;
        logic [1:0]   ctrl;
        int           exp_accept;
        int           exp_drop;
        int           exp_hdr_err;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_byte       = '0;
        out_hdr_ready = 1'b1;
        cfg_wr        = 1'b0;
        cfg_rd        = 1'b0;
        cfg_addr      = '0;
        cfg_wdata     = '0;
        exp_accept    = 0;
        exp_drop      = 0;
        exp_hdr_err   = 0;
        fill_table();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (frame_table[i].short_frame) begin
                exp_hdr_err++;
            end else if (frame_accepted(frame_table[i])) begin
                exp_accept++;
            end else begin
                exp_drop++;
            end
        end

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        reg_write(eth_rx_pkg::REG_MAC_LO, LOCAL_MAC[31:0]);
        reg_write(eth_rx_pkg::REG_MAC_HI, {16'd0, LOCAL_MAC[47:32]});
        reg_write(eth_rx_pkg::REG_CTRL, 32'd1);
        ctrl = 2'b01;

        for (int i = 0; i < NUM_FRAMES; i++) begin
            e = frame_table[i];
            if ({e.promisc, e.rx_enable} != ctrl) begin
                // cfg is read when the filter takes a header
                wait_decided(i);
                ctrl = {e.promisc, e.rx_enable};
                reg_write(eth_rx_pkg::REG_CTRL, {30'd0, ctrl});
            end
            if (!e.short_frame && frame_accepted(e)) begin
                queue_expected(i);
            end
            send_frame(i);
            // inter-frame gap as on the wire
            repeat (IFG_CYCLES) @(posedge clk);
            #1;
        end

        wait_decided(NUM_FRAMES);
        while (exp_hdrs.size() != 0 || exp_bytes.size() != 0) begin
            @(posedge clk);
            #1;
        end

        check_reg(eth_rx_pkg::REG_CNT_ACCEPT, exp_accept, "accept counter");
        check_reg(eth_rx_pkg::REG_CNT_DROP, exp_drop, "drop counter");
        check_reg(eth_rx_pkg::REG_CNT_HDR_ERR, exp_hdr_err, "header error counter");
        check_reg(eth_rx_pkg::REG_MAC_LO, LOCAL_MAC[31:0], "MAC_LO");
        check_reg(eth_rx_pkg::REG_MAC_HI, {16'd0, LOCAL_MAC[47:32]}, "MAC_HI");

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // out_ready changes 1 ns after the edge and transfers are sampled 1 ns before the next
    initial begin : output_checker
        integer                 rnd;
        eth_rx_pkg::eth_hdr_t   exp_h;
        eth_rx_pkg::axis_byte_t exp_b;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            out_ready = rnd[0];
            #2;
            if (out_hdr_valid && out_hdr_ready) begin
                check_count++;
                if (exp_hdrs.size() == 0) begin
                    report_error($sformatf("header 0x%028h from a frame that should drop",
                                           out_hdr));
                end else begin
                    exp_h = exp_hdrs.pop_front();
                    if (out_hdr !== exp_h) begin
                        report_error($sformatf("header 0x%028h, expected 0x%028h",
                                               out_hdr, exp_h));
                    end
                end
            end
            if (out_valid && out_ready) begin
                check_count++;
                if (exp_bytes.size() == 0) begin
                    report_error($sformatf("unexpected payload byte 0x%02h", out_byte.data));
                end else begin
                    exp_b = exp_bytes.pop_front();
                    if (out_byte !== exp_b) begin
                        report_error($sformatf("byte 0x%02h last %0b, expected 0x%02h last %0b",
                                               out_byte.data, out_byte.last,
                                               exp_b.data, exp_b.last));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
